//--- source/mcu_proto_pkg.sv
package mcu_proto_pkg;

    localparam int BYTE_WIDTH = 8;

    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // First byte of every frame
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    localparam byte_t FPGA_ID = 8'h64;  // Reply to CMD_IDENTIFY

endpackage

//--- source/mcu_regs_pkg.sv
package mcu_regs_pkg;

    localparam int BUF_DEPTH      = 512;
    localparam int MEM_DATA_WIDTH = 16;
    localparam int MEM_ADDR_WIDTH = 32;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR     = 8'd1,
        REG_CFG_SCR     = 8'd2,
        REG_CFG_VERSION = 8'd3,
        REG_STATUS      = 8'd4
    } reg_addr_e;

    typedef logic [31:0] reg_word_t;

    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_index_t;
    typedef logic [MEM_DATA_WIDTH-1:0]    mem_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]    mem_addr_t;  // Byte address

    // One write word, read either as transfer control or as configuration
    typedef union packed {
        reg_word_t raw;
        struct packed {
            logic [16:0] unused;
            logic [9:0]  length;     // Words, 1 to 512
            logic [1:0]  reserved;
            logic        direction;  // 1 writes to memory
            logic        stop;
            logic        start;
        } mem_scr;
        struct packed {
            logic [19:0] unused;
            logic [11:0] flags;
        } cfg;
    } reg_word_u;

    localparam reg_word_t CFG_VERSION = 32'h53437632;

endpackage

//--- source/mcu_spi_slave.sv
`timescale 1ns/1ps

module mcu_spi_slave (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mcu_clk,
    input  logic                 mcu_cs,
    input  logic                 mcu_mosi,
    input  mcu_proto_pkg::byte_t tx_data,
    output logic                 mcu_miso,
    output logic                 frame_start,
    output logic                 data_ready,
    output mcu_proto_pkg::byte_t rx_data
);

    logic [1:0] clk_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       clk_last;
    logic       cs_last;
    logic       clk_rising;
    logic       clk_falling;
    logic       selected;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;

    mcu_proto_pkg::byte_t tx_shift;

    always_ff @(posedge clk) begin
        clk_sync <= {clk_sync[0], mcu_clk};
        cs_sync <= {cs_sync[0], mcu_cs};
        mosi_sync <= {mosi_sync[0], mcu_mosi};
        clk_last <= clk_sync[1];
    end

    assign clk_rising = clk_sync[1] && !clk_last;
    assign clk_falling = !clk_sync[1] && clk_last;
    assign selected = !cs_sync[1];

    always_ff @(posedge clk) begin
        frame_start <= 1'b0;
        data_ready <= 1'b0;
        if (reset) begin
            cs_last <= 1'b1;
            bit_count <= 3'd0;
        end else begin
            cs_last <= cs_sync[1];
            if (cs_last && selected) begin
                frame_start <= 1'b1;
            end
            if (!selected) begin
                bit_count <= 3'd0;  // A deselect drops any partial byte
            end else if (clk_rising) begin
                bit_count <= bit_count + 3'd1;
                data_ready <= (bit_count == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (selected && clk_rising) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_count == 3'd7) begin
                rx_data <= {rx_shift, mosi_sync[1]};
            end
        end

        // The next reply byte is taken between bytes, never inside one
        if (frame_start) begin
            tx_shift <= tx_data;
        end else if (selected && clk_falling) begin
            if (bit_count == 3'd0) begin
                tx_shift <= tx_data;
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign mcu_miso = tx_shift[7];

endmodule

//--- source/mcu_cmd_decoder.sv
`timescale 1ns/1ps

module mcu_cmd_decoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       frame_start,
    input  logic                       data_ready,
    input  mcu_proto_pkg::byte_t       rx_data,
    input  mcu_regs_pkg::reg_word_t    reg_rdata,
    input  mcu_regs_pkg::mem_word_t    buf_rdata,
    output mcu_proto_pkg::byte_t       tx_data,
    output logic                       reg_read,
    output logic                       reg_write,
    output logic [7:0]                 address,
    output mcu_regs_pkg::reg_word_t    reg_wdata,
    output logic                       buf_read,
    output logic                       buf_write,
    output mcu_regs_pkg::buf_index_t   buf_addr,
    output mcu_regs_pkg::mem_word_t    buf_wdata
);

    mcu_proto_pkg::phase_e phase;
    mcu_proto_pkg::cmd_e   cmd;
    logic [1:0]            counter;  // Byte within the current word

    // ==================================================================
    // Frame phases

    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;

        if (reset) begin
            phase <= mcu_proto_pkg::PHASE_NOP;
            cmd <= mcu_proto_pkg::CMD_IDENTIFY;
            counter <= 2'd0;
        end else begin
            if (frame_start) begin
                phase <= mcu_proto_pkg::PHASE_CMD;
                counter <= 2'd0;
            end

            if (reg_read || reg_write) begin
                address <= address + 8'd1;
            end
            if (buf_read || buf_write) begin
                buf_addr <= buf_addr + 9'd1;
            end

            if (data_ready) begin
                case (phase)
                    mcu_proto_pkg::PHASE_CMD: begin
                        cmd <= mcu_proto_pkg::cmd_e'(rx_data);
                        if (rx_data == mcu_proto_pkg::CMD_IDENTIFY) begin
                            phase <= mcu_proto_pkg::PHASE_NOP;  // No address byte
                        end else begin
                            phase <= mcu_proto_pkg::PHASE_ADDRESS;
                        end
                    end

                    mcu_proto_pkg::PHASE_ADDRESS: begin
                        phase <= mcu_proto_pkg::PHASE_DATA;
                        address <= rx_data;
                        buf_addr <= {rx_data, 1'b0};  // Address byte picks a word pair
                        reg_read <= (cmd == mcu_proto_pkg::CMD_REG_READ);
                        buf_read <= (cmd == mcu_proto_pkg::CMD_MEM_READ);
                    end

                    mcu_proto_pkg::PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            mcu_proto_pkg::CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);  // Stream the next register
                            end
                            mcu_proto_pkg::CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: 8] <= rx_data;
                                reg_write <= (counter == 2'd3);
                            end
                            mcu_proto_pkg::CMD_MEM_READ: begin
                                buf_read <= counter[0];
                            end
                            mcu_proto_pkg::CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                end else begin
                                    buf_wdata[15:8] <= rx_data;
                                end
                                buf_write <= counter[0];
                            end
                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // ==================================================================
    // Reply byte

    always_comb begin
        case (cmd)
            mcu_proto_pkg::CMD_IDENTIFY: tx_data = mcu_proto_pkg::FPGA_ID;
            mcu_proto_pkg::CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: 8];
            mcu_proto_pkg::CMD_MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            default:                     tx_data = 8'h00;
        endcase
    end

endmodule

//--- source/mcu_mem_transfer.sv
`timescale 1ns/1ps

module mcu_mem_transfer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      buf_read,
    input  logic                      buf_write,
    input  mcu_regs_pkg::buf_index_t  buf_addr,
    input  mcu_regs_pkg::mem_word_t   buf_wdata,
    input  logic                      mem_start,
    input  logic                      mem_stop,
    input  logic                      mem_direction,
    input  mcu_regs_pkg::buf_index_t  mem_length,
    input  mcu_regs_pkg::mem_addr_t   mem_base,
    input  logic                      mem_ack,
    input  mcu_regs_pkg::mem_word_t   mem_rdata,
    output mcu_regs_pkg::mem_word_t   buf_rdata,
    output logic                      mem_busy,
    output logic                      mem_request,
    output logic                      mem_write,
    output mcu_regs_pkg::mem_addr_t   mem_address,
    output mcu_regs_pkg::mem_word_t   mem_wdata
);

    mcu_regs_pkg::mem_word_t  buffer [0:mcu_regs_pkg::BUF_DEPTH-1];
    mcu_regs_pkg::buf_index_t word_index;

    logic stop_pending;
    logic word_issue;
    logic word_done;
    logic last_word;

    assign word_issue = mem_busy && !mem_request;
    assign word_done = mem_request && mem_ack;
    assign last_word = (word_index == mem_length) || stop_pending;

    // ==================================================================
    // Staging buffer, host port and engine port

    always_ff @(posedge clk) begin
        if (buf_read) begin
            buf_rdata <= buffer[buf_addr];
        end
        if (buf_write) begin
            buffer[buf_addr] <= buf_wdata;
        end
        if (word_issue) begin
            mem_wdata <= buffer[word_index];
        end
        if (word_done && !mem_write) begin
            buffer[word_index] <= mem_rdata;
        end
    end

    // ==================================================================
    // Transfer engine

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
            mem_request <= 1'b0;
            stop_pending <= 1'b0;
        end else begin
            if (mem_stop) begin
                stop_pending <= mem_busy;
            end else if (mem_start && !mem_busy) begin
                mem_busy <= 1'b1;
                mem_write <= mem_direction;
                mem_address <= mem_base;
                word_index <= '0;
            end

            if (word_issue) begin
                mem_request <= 1'b1;
            end

            if (word_done) begin
                mem_request <= 1'b0;
                mem_address <= mem_address + 32'd2;
                word_index <= word_index + 9'd1;
                if (last_word) begin
                    mem_busy <= 1'b0;
                    stop_pending <= 1'b0;
                end
            end
        end
    end

    // The memory side may only answer a request that is pending
    assert property (@(posedge clk) disable iff (reset) mem_ack |-> mem_request)
        else $error("Memory ack without a request");

endmodule

//--- source/mcu_reg_file.sv
`timescale 1ns/1ps

module mcu_reg_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_read,
    input  logic                      reg_write,
    input  logic [7:0]                address,
    input  mcu_regs_pkg::reg_word_t   reg_wdata,
    input  logic                      mem_busy,
    input  logic                      button,
    input  logic                      sd_det,
    output mcu_regs_pkg::reg_word_t   reg_rdata,
    output logic                      mem_start,
    output logic                      mem_stop,
    output logic                      mem_direction,
    output mcu_regs_pkg::buf_index_t  mem_length,
    output mcu_regs_pkg::mem_addr_t   mem_base
);

    mcu_regs_pkg::reg_word_u write_word;

    logic [11:0] cfg_flags;  // Bit 0 is the bootloader flag
    logic [2:0]  button_ff;
    logic [2:0]  sd_det_ff;

    assign write_word.raw = reg_wdata;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[1:0], button};
        sd_det_ff <= {sd_det_ff[1:0], sd_det};
    end

    // Both inputs are active low
    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (mcu_regs_pkg::reg_addr_e'(address))
                mcu_regs_pkg::REG_MEM_ADDRESS: reg_rdata <= mem_base;
                mcu_regs_pkg::REG_MEM_SCR:     reg_rdata <= {28'd0, mem_busy, 3'b000};
                mcu_regs_pkg::REG_CFG_SCR:     reg_rdata <= {20'd0, cfg_flags};
                mcu_regs_pkg::REG_CFG_VERSION: reg_rdata <= mcu_regs_pkg::CFG_VERSION;
                mcu_regs_pkg::REG_STATUS:      reg_rdata <= {30'd0, ~button_ff[2], ~sd_det_ff[2]};
                default:                       reg_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        mem_start <= 1'b0;
        mem_stop <= 1'b0;

        if (reset) begin
            cfg_flags <= 12'h001;
        end else if (reg_write) begin
            case (mcu_regs_pkg::reg_addr_e'(address))
                mcu_regs_pkg::REG_MEM_ADDRESS: begin
                    mem_base <= write_word.raw;
                end
                mcu_regs_pkg::REG_MEM_SCR: begin
                    mem_start <= write_word.mem_scr.start;
                    mem_stop <= write_word.mem_scr.stop;
                    mem_direction <= write_word.mem_scr.direction;
                    mem_length <= mcu_regs_pkg::buf_index_t'(write_word.mem_scr.length - 10'd1);
                end
                mcu_regs_pkg::REG_CFG_SCR: begin
                    cfg_flags <= write_word.cfg.flags;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/mcu_bridge.sv
`timescale 1ns/1ps

module mcu_bridge (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mcu_clk,
    input  logic                     mcu_cs,
    input  logic                     mcu_mosi,
    input  logic                     button,
    input  logic                     sd_det,
    input  logic                     mem_ack,
    input  mcu_regs_pkg::mem_word_t  mem_rdata,
    output logic                     mcu_miso,
    output logic                     mem_request,
    output logic                     mem_write,
    output mcu_regs_pkg::mem_addr_t  mem_address,
    output mcu_regs_pkg::mem_word_t  mem_wdata
);

    logic                     frame_start;
    logic                     data_ready;
    mcu_proto_pkg::byte_t     rx_data;
    mcu_proto_pkg::byte_t     tx_data;
    logic                     reg_read;
    logic                     reg_write;
    logic [7:0]               address;
    mcu_regs_pkg::reg_word_t  reg_wdata;
    mcu_regs_pkg::reg_word_t  reg_rdata;
    logic                     buf_read;
    logic                     buf_write;
    mcu_regs_pkg::buf_index_t buf_addr;
    mcu_regs_pkg::mem_word_t  buf_wdata;
    mcu_regs_pkg::mem_word_t  buf_rdata;
    logic                     mem_start;
    logic                     mem_stop;
    logic                     mem_direction;
    mcu_regs_pkg::buf_index_t mem_length;
    mcu_regs_pkg::mem_addr_t  mem_base;
    logic                     mem_busy;

    // ==================================================================
    // SPI transport and command protocol

    mcu_spi_slave mcu_spi_slave_i (
        .clk         (clk),
        .reset       (reset),
        .mcu_clk     (mcu_clk),
        .mcu_cs      (mcu_cs),
        .mcu_mosi    (mcu_mosi),
        .tx_data     (tx_data),
        .mcu_miso    (mcu_miso),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data)
    );

    mcu_cmd_decoder mcu_cmd_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data),
        .reg_rdata   (reg_rdata),
        .buf_rdata   (buf_rdata),
        .tx_data     (tx_data),
        .reg_read    (reg_read),
        .reg_write   (reg_write),
        .address     (address),
        .reg_wdata   (reg_wdata),
        .buf_read    (buf_read),
        .buf_write   (buf_write),
        .buf_addr    (buf_addr),
        .buf_wdata   (buf_wdata)
    );

    // ==================================================================
    // Registers and memory transfers

    mcu_reg_file mcu_reg_file_i (
        .clk           (clk),
        .reset         (reset),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .address       (address),
        .reg_wdata     (reg_wdata),
        .mem_busy      (mem_busy),
        .button        (button),
        .sd_det        (sd_det),
        .reg_rdata     (reg_rdata),
        .mem_start     (mem_start),
        .mem_stop      (mem_stop),
        .mem_direction (mem_direction),
        .mem_length    (mem_length),
        .mem_base      (mem_base)
    );

    mcu_mem_transfer mcu_mem_transfer_i (
        .clk           (clk),
        .reset         (reset),
        .buf_read      (buf_read),
        .buf_write     (buf_write),
        .buf_addr      (buf_addr),
        .buf_wdata     (buf_wdata),
        .mem_start     (mem_start),
        .mem_stop      (mem_stop),
        .mem_direction (mem_direction),
        .mem_length    (mem_length),
        .mem_base      (mem_base),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .buf_rdata     (buf_rdata),
        .mem_busy      (mem_busy),
        .mem_request   (mem_request),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 50;  // 100 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset = 1'b0;
    end

endmodule

//--- tests/mcu_bridge_tb.sv
`timescale 1ns/1ps

module mcu_bridge_tb;

    localparam int HALF_BIT      = 4;   // Clk cycles per SPI clock phase
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_TIMEOUT = 50;
    localparam int POLL_LIMIT    = 40;  // Status reads before a transfer counts as stuck

    logic                    clk;
    logic                    reset;
    logic                    mcu_clk;
    logic                    mcu_cs;
    logic                    mcu_mosi;
    logic                    mcu_miso;
    logic                    button;
    logic                    sd_det;
    logic                    mem_ack = 1'b0;
    logic                    mem_request;
    logic                    mem_write;
    mcu_regs_pkg::mem_word_t mem_rdata = '0;
    mcu_regs_pkg::mem_addr_t mem_address;
    mcu_regs_pkg::mem_word_t mem_wdata;

    mcu_regs_pkg::mem_word_t mem_model [mcu_regs_pkg::mem_addr_t];
    mcu_regs_pkg::reg_word_t read_words [0:1];
    mcu_regs_pkg::mem_word_t sent_words [0:7];
    mcu_regs_pkg::mem_word_t got_words [0:7];

    integer seed        = 31571;
    int     ack_delay   = -1;
    int     check_count = 0;
    int     error_count = 0;

    tb_clock_gen tb_clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    mcu_bridge mcu_bridge_i (
        .clk         (clk),
        .reset       (reset),
        .mcu_clk     (mcu_clk),
        .mcu_cs      (mcu_cs),
        .mcu_mosi    (mcu_mosi),
        .button      (button),
        .sd_det      (sd_det),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .mcu_miso    (mcu_miso),
        .mem_request (mem_request),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

    // ==================================================================
    // Memory model

    function automatic mcu_regs_pkg::mem_word_t fill_word(input mcu_regs_pkg::mem_addr_t addr);
        return addr[31:16] ^ addr[15:0];
    endfunction

    always @(posedge clk) begin
        #DRIVE_DELAY;
        mem_ack = 1'b0;
        if (mem_request === 1'b1) begin
            if (ack_delay < 0) begin
                ack_delay = $random(seed) % 6;  // 0 to 5 cycles of latency
                if (ack_delay < 0) begin
                    ack_delay = -ack_delay;
                end
            end
            if (ack_delay == 0) begin
                if (mem_write) begin
                    mem_model[mem_address] = mem_wdata;
                end else if (mem_model.exists(mem_address)) begin
                    mem_rdata = mem_model[mem_address];
                end else begin
                    mem_rdata = fill_word(mem_address);
                end
                mem_ack = 1'b1;
                ack_delay = -1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    // ==================================================================
    // SPI host

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic begin_frame();
        mcu_cs = 1'b0;
        wait_cycles(HALF_BIT);
    endtask

    task automatic end_frame();
        wait_cycles(HALF_BIT);
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        wait_cycles(2 * HALF_BIT);
    endtask

    // Mode 0, MSB first, host samples MISO as it raises the clock
    task automatic exchange_byte(input mcu_proto_pkg::byte_t out_byte,
                                 output mcu_proto_pkg::byte_t in_byte);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi = out_byte[i];
            wait_cycles(HALF_BIT);
            in_byte[i] = mcu_miso;
            mcu_clk = 1'b1;
            wait_cycles(HALF_BIT);
            mcu_clk = 1'b0;
        end
    endtask

    task automatic write_register(input logic [7:0] addr, input mcu_regs_pkg::reg_word_t value);
        mcu_proto_pkg::byte_t reply;
        begin_frame();
        exchange_byte(mcu_proto_pkg::CMD_REG_WRITE, reply);
        exchange_byte(addr, reply);
        for (int b = 0; b < 4; b++) begin
            exchange_byte(value[8*b +: 8], reply);  // Little-endian
        end
        end_frame();
    endtask

    task automatic read_registers(input logic [7:0] addr, input int count);
        mcu_proto_pkg::byte_t reply;
        begin_frame();
        exchange_byte(mcu_proto_pkg::CMD_REG_READ, reply);
        exchange_byte(addr, reply);
        for (int w = 0; w < count; w++) begin
            for (int b = 0; b < 4; b++) begin
                exchange_byte(8'h00, reply);
                read_words[w][8*b +: 8] = reply;
            end
        end
        end_frame();
    endtask

    // The address byte selects a pair of buffer words
    task automatic write_buffer(input logic [7:0] pair, input int count);
        mcu_proto_pkg::byte_t reply;
        begin_frame();
        exchange_byte(mcu_proto_pkg::CMD_MEM_WRITE, reply);
        exchange_byte(pair, reply);
        for (int w = 0; w < count; w++) begin
            exchange_byte(sent_words[w][15:8], reply);
            exchange_byte(sent_words[w][7:0], reply);
        end
        end_frame();
    endtask

    task automatic read_buffer(input logic [7:0] pair, input int count);
        mcu_proto_pkg::byte_t reply;
        begin_frame();
        exchange_byte(mcu_proto_pkg::CMD_MEM_READ, reply);
        exchange_byte(pair, reply);
        for (int w = 0; w < count; w++) begin
            exchange_byte(8'h00, reply);
            got_words[w][15:8] = reply;
            exchange_byte(8'h00, reply);
            got_words[w][7:0] = reply;
        end
        end_frame();
    endtask

    // ==================================================================
    // Checks and transfer helpers

    task automatic check_byte(input string name, input mcu_proto_pkg::byte_t actual,
                              input mcu_proto_pkg::byte_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_reg(input string name, input mcu_regs_pkg::reg_word_t actual,
                             input mcu_regs_pkg::reg_word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_mem(input string name, input mcu_regs_pkg::mem_word_t actual,
                             input mcu_regs_pkg::mem_word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %-22s %0d errors", name, error_count - errors_before);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            wait_cycles(1);
            cycles++;
        end
        if (reset !== 1'b0) begin
            error_count++;
            $display("Timeout: reset was never released");
        end
    endtask

    // Length in bits 14..5, direction in bit 2, start in bit 0
    function automatic mcu_regs_pkg::reg_word_t control_word(input int count,
                                                             input logic to_memory);
        return (mcu_regs_pkg::reg_word_t'(count) << 5)
            | (mcu_regs_pkg::reg_word_t'(to_memory) << 2) | 32'd1;
    endfunction

    task automatic wait_transfer_done();
        logic busy;
        busy = 1'b1;
        for (int poll = 0; poll < POLL_LIMIT && busy !== 1'b0; poll++) begin
            read_registers(mcu_regs_pkg::REG_MEM_SCR, 1);
            busy = read_words[0][3];
        end
        if (busy !== 1'b0) begin
            error_count++;
            $display("Timeout: transfer still busy after %0d status reads", POLL_LIMIT);
        end
    endtask

    task automatic run_transfer(input mcu_regs_pkg::mem_addr_t base, input int count,
                                input logic to_memory);
        write_register(mcu_regs_pkg::REG_MEM_ADDRESS, base);
        read_registers(mcu_regs_pkg::REG_MEM_ADDRESS, 1);
        check_reg("mem_address", read_words[0], base);
        write_register(mcu_regs_pkg::REG_MEM_SCR, control_word(count, to_memory));
        wait_transfer_done();
    endtask

    // ==================================================================
    // Directed tests

    task automatic identify_check();
        int                   errors_before;
        mcu_proto_pkg::byte_t reply;
        errors_before = error_count;
        begin_frame();
        exchange_byte(mcu_proto_pkg::CMD_IDENTIFY, reply);
        exchange_byte(8'h00, reply);
        end_frame();
        check_byte("identify reply", reply, mcu_proto_pkg::FPGA_ID);
        report_test("identify", errors_before);
    endtask

    task automatic register_access();
        int errors_before;
        errors_before = error_count;
        read_registers(mcu_regs_pkg::REG_CFG_SCR, 1);
        check_reg("cfg_scr after reset", read_words[0], 32'h0000_0001);  // Bootloader flag only
        write_register(mcu_regs_pkg::REG_CFG_SCR, 32'hffff_f5a3);
        read_registers(mcu_regs_pkg::REG_CFG_SCR, 1);
        check_reg("cfg_scr", read_words[0], 32'h0000_05a3);  // Only 12 flag bits are kept
        read_registers(mcu_regs_pkg::REG_CFG_VERSION, 1);
        check_reg("cfg_version", read_words[0], mcu_regs_pkg::CFG_VERSION);
        read_registers(mcu_regs_pkg::REG_CFG_SCR, 2);
        check_reg("streamed cfg_scr", read_words[0], 32'h0000_05a3);
        check_reg("streamed cfg_version", read_words[1], mcu_regs_pkg::CFG_VERSION);
        report_test("registers", errors_before);
    endtask

    task automatic buffer_round_trip();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 4; i++) begin
            sent_words[i] = mcu_regs_pkg::mem_word_t'($random(seed));
        end
        write_buffer(8'd2, 4);
        read_buffer(8'd2, 4);
        for (int i = 0; i < 4; i++) begin
            check_mem($sformatf("buffer word %0d", i), got_words[i], sent_words[i]);
        end
        report_test("buffer", errors_before);
    endtask

    task automatic transfer_to_memory();
        int                      errors_before;
        mcu_regs_pkg::mem_addr_t base;
        mcu_regs_pkg::mem_addr_t addr;
        errors_before = error_count;
        base = 32'h0000_2000;
        for (int i = 0; i < 6; i++) begin
            sent_words[i] = mcu_regs_pkg::mem_word_t'($random(seed));
        end
        write_buffer(8'd0, 6);
        run_transfer(base, 6, 1'b1);
        for (int i = 0; i < 6; i++) begin
            addr = base + mcu_regs_pkg::mem_addr_t'(2 * i);
            if (!mem_model.exists(addr)) begin
                error_count++;
                $display("Memory word at %h was never written", addr);
            end else begin
                check_mem($sformatf("memory word %0d", i), mem_model[addr], sent_words[i]);
            end
        end
        if (mem_model.exists(base + 32'd12)) begin
            error_count++;
            $display("Transfer wrote memory past its length");
        end
        report_test("transfer to memory", errors_before);
    endtask

    task automatic transfer_from_memory();
        int                      errors_before;
        mcu_regs_pkg::mem_addr_t base;
        errors_before = error_count;
        base = 32'h0001_3100;
        for (int i = 0; i < 5; i++) begin
            sent_words[i] = mcu_regs_pkg::mem_word_t'($random(seed));
            mem_model[base + mcu_regs_pkg::mem_addr_t'(2 * i)] = sent_words[i];
        end
        run_transfer(base, 5, 1'b0);
        read_buffer(8'd0, 5);
        for (int i = 0; i < 5; i++) begin
            check_mem($sformatf("buffer word %0d", i), got_words[i], sent_words[i]);
        end
        report_test("transfer from memory", errors_before);
    endtask

    task automatic status_inputs();
        int errors_before;
        errors_before = error_count;
        for (int k = 0; k < 4; k++) begin
            button = k[1];
            sd_det = k[0];
            wait_cycles(5);  // Lets the three-stage synchronizers settle
            read_registers(mcu_regs_pkg::REG_STATUS, 1);
            check_reg("status", read_words[0], {30'd0, ~k[1], ~k[0]});
        end
        report_test("inputs", errors_before);
    endtask

    initial begin
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        button = 1'b1;
        sd_det = 1'b1;
        wait_reset_release();

        identify_check();
        register_access();
        buffer_round_trip();
        transfer_to_memory();
        transfer_from_memory();
        status_inputs();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- mcu_bridge.f
source/mcu_proto_pkg.sv
source/mcu_regs_pkg.sv
source/mcu_spi_slave.sv
source/mcu_cmd_decoder.sv
source/mcu_mem_transfer.sv
source/mcu_reg_file.sv
source/mcu_bridge.sv
tests/tb_clock_gen.sv
tests/mcu_bridge_tb.sv

//--- Bender.yml
package:
  name: mcu_bridge

sources:
  - source/mcu_proto_pkg.sv
  - source/mcu_regs_pkg.sv
  - source/mcu_spi_slave.sv
  - source/mcu_cmd_decoder.sv
  - source/mcu_mem_transfer.sv
  - source/mcu_reg_file.sv
  - source/mcu_bridge.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/mcu_bridge_tb.sv
